// File: sources.f
bus_map_pkg.sv
periph_pkg.sv
addr_decode.sv
boot_rom.sv
data_ram.sv
seven_seg.sv
board_io.sv
baud_timer.sv
uart_tx_fsm.sv
irq_ctrl.sv
super6502_top.sv
tb_super6502.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the super6502 peripheral testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing -sv -Wno-fatal -f sources.f \
    --top-module tb_super6502 -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build did not succeed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Testbench failed" "$log"; then
    exit 1
fi
exit 0

// File: tb_super6502.sv
`timescale 1ns/1ps

module tb_super6502;

    localparam int k_write   = 0;
    localparam int k_read    = 1;
    localparam int k_hex     = 2;
    localparam int k_led     = 3;
    localparam int k_sw      = 4;
    localparam int k_btn     = 5;
    localparam int k_irqb    = 6;
    localparam int k_uart    = 7;
    localparam int k_uart_bp = 8;  // frame plus a second write while busy
    localparam int bit_clks  = periph_pkg::uart_clks_per_bit;
    localparam int wait_max  = 4 * bit_clks;

    // boot rom image, eight bytes per line
    localparam logic [7:0] rom_image [64] = '{
        8'hA2, 8'hFF, 8'h9A, 8'h58, 8'hA9, 8'h48, 8'h8D, 8'hF4,
        8'h7F, 8'hAD, 8'hF5, 8'h7F, 8'hD0, 8'hFB, 8'hAD, 8'hF7,
        8'h7F, 8'h8D, 8'hF7, 8'h7F, 8'h8D, 8'hF0, 8'h7F, 8'h4C,
        8'h0E, 8'h80, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA,
        8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA,
        8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'hEA,
        8'h48, 8'hA9, 8'h00, 8'h8D, 8'hF6, 8'h7F, 8'h68, 8'h40,
        8'hEA, 8'hEA, 8'h30, 8'h80, 8'h00, 8'h80, 8'h30, 8'h80
    };

    // lit segments per hex digit, a in bit 0
    localparam logic [6:0] seg_on [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic        clk;
    logic        rst;
    logic [15:0] cpu_addr;
    logic        cpu_rwb;
    logic [7:0]  cpu_data_in;
    logic        button;
    logic [7:0]  sw;
    logic [7:0]  cpu_data_out;
    logic        cpu_irqb;
    logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;
    logic [7:0]  led;
    logic        uart_txd;

    int          op_q [$];
    int          grp_q [$];
    logic [15:0] addr_q [$];
    logic [7:0]  data_q [$];
    logic [7:0]  exp_q [$];
    string       grp_name [6] = '{"boot rom", "ram", "display and board io",
                                  "uart frame", "uart back-pressure", "interrupts"};

    int n_checks   = 0;
    int n_errors   = 0;
    int n_tests    = 0;
    int grp_checks = 0;
    int grp_errors = 0;
    bit timed_out  = 1'b0;

    super6502_top super6502_top_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_rwb      (cpu_rwb),
        .cpu_data_in  (cpu_data_in),
        .button       (button),
        .sw           (sw),
        .cpu_data_out (cpu_data_out),
        .cpu_irqb     (cpu_irqb),
        .hex0         (hex0),
        .hex1         (hex1),
        .hex2         (hex2),
        .hex3         (hex3),
        .hex4         (hex4),
        .hex5         (hex5),
        .led          (led),
        .uart_txd     (uart_txd)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        n_errors++;
        timed_out = 1'b1;
        $display("timeout at %0t ns: %s", $time, what);
    endtask

    task automatic add_row(input int grp, input int op, input logic [15:0] a,
                           input logic [7:0] d, input logic [7:0] exp);
        grp_q.push_back(grp);
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(exp);
    endtask

    function automatic logic [7:0] seg_expect(input logic [3:0] nib);
        return {1'b0, ~seg_on[nib]};  // active low
    endfunction

    function automatic logic [6:0] digit(input logic [15:0] idx);
        case (idx)
            16'd0:   return hex0;
            16'd1:   return hex1;
            16'd2:   return hex2;
            16'd3:   return hex3;
            16'd4:   return hex4;
            default: return hex5;
        endcase
    endfunction

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu_addr    <= a;
        cpu_rwb     <= 1'b0;
        cpu_data_in <= d;
        @(posedge clk);
        cpu_rwb <= 1'b1;  // exactly one write edge
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_rwb  <= 1'b1;
        @(negedge clk);
        d = cpu_data_out;
    endtask

    task automatic receive_frame(output logic [7:0] got);
        int n;
        got = 8'h00;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (uart_txd !== 1'b0 && n < wait_max);
        if (uart_txd !== 1'b0) begin
            note_timeout("uart start bit never appeared");
            return;
        end
        check(n, 1, "uart start delay in cycles");
        repeat (bit_clks / 2) @(negedge clk);  // centre of start bit
        check(uart_txd, 1'b0, "uart start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            got[i] = uart_txd;
        end
        repeat (bit_clks) @(negedge clk);
        check(uart_txd, 1'b1, "uart stop bit");
    endtask

    task automatic wait_idle();
        logic [7:0] stat;
        int n;
        n = 0;
        do begin
            bus_read(16'h7FF5, stat);
            n++;
        end while (stat[0] !== 1'b0 && n < wait_max);
        if (stat[0] !== 1'b0) note_timeout("uart stayed busy after the frame");
        check(stat, 8'h00, "uart status after frame");
    endtask

    task automatic run_uart(input logic [7:0] d, input logic [7:0] exp, input bit second);
        logic [7:0] got;
        logic [7:0] stat;
        int         low_cnt;
        low_cnt = 0;
        bus_write(16'h7FF4, d);
        fork
            receive_frame(got);
            begin
                bus_read(16'h7FF5, stat);
                check(stat, 8'h01, "uart status during frame");
                if (second) bus_write(16'h7FF4, ~d);
            end
        join
        if (timed_out) return;
        check(got, exp, "uart received byte");
        wait_idle();
        repeat (2 * bit_clks) begin  // line must stay idle
            @(negedge clk);
            if (uart_txd !== 1'b1) low_cnt++;
        end
        check(low_cnt, 0, "uart line low after frame");
    endtask

    task automatic run_row(input int r);
        logic [7:0] rd;
        case (op_q[r])
            k_write: bus_write(addr_q[r], data_q[r]);
            k_read: begin
                bus_read(addr_q[r], rd);
                check(rd, exp_q[r], $sformatf("read of %h", addr_q[r]));
            end
            k_hex: begin
                @(negedge clk);
                check(digit(addr_q[r]), exp_q[r], $sformatf("hex%0d", addr_q[r]));
            end
            k_led: begin
                @(negedge clk);
                check(led, exp_q[r], "led register");
            end
            k_sw: begin
                @(posedge clk);
                sw <= data_q[r];
            end
            k_btn: begin
                @(posedge clk);
                button <= data_q[r][0];
            end
            k_irqb: begin
                @(negedge clk);
                check(cpu_irqb, exp_q[r][0], "cpu_irqb level");
            end
            k_uart:  run_uart(data_q[r], exp_q[r], 1'b0);
            default: run_uart(data_q[r], exp_q[r], 1'b1);
        endcase
    endtask

    task automatic build_table();
        logic [7:0]  v;
        logic [7:0]  start;
        logic [7:0]  ram_a [8];
        logic [7:0]  ram_v [8];
        logic [7:0]  hexb [3];
        logic [15:0] ra;
        for (int i = 0; i < 64; i++) begin
            add_row(0, k_read, 16'h8000 + 16'(i), 8'h00, rom_image[i]);
            add_row(0, k_read, 16'hC000 + 16'(i), 8'h00, rom_image[i]);  // alias
        end
        add_row(0, k_read, 16'h7FF3, 8'h00, 8'hFF);
        start = 8'($urandom);
        for (int i = 0; i < 8; i++) begin
            ram_a[i] = start + 8'(i * 37);  // odd stride keeps them distinct
            ram_v[i] = 8'($urandom);
            add_row(1, k_write, {8'h00, ram_a[i]}, ram_v[i], 8'h00);
        end
        for (int i = 0; i < 8; i++) add_row(1, k_read, {8'h00, ram_a[i]}, 8'h00, ram_v[i]);
        for (int i = 0; i < 4; i++) begin
            ra = 16'h8000 | {8'h00, ram_a[i]};  // rom address over a used ram byte
            add_row(1, k_write, ra, 8'($urandom), 8'h00);
            add_row(1, k_read, ra, 8'h00, rom_image[ram_a[i][5:0]]);
            add_row(1, k_read, {8'h00, ram_a[i]}, 8'h00, ram_v[i]);
        end
        add_row(2, k_led, 16'h0000, 8'h00, 8'h00);
        add_row(2, k_irqb, 16'h0000, 8'h00, 8'h01);
        add_row(2, k_read, 16'h7FF5, 8'h00, 8'h00);
        for (int k = 0; k < 3; k++) begin
            hexb[k] = 8'($urandom);
            add_row(2, k_write, 16'h7FF0 + 16'(k), hexb[k], 8'h00);
        end
        for (int k = 0; k < 3; k++) begin
            add_row(2, k_hex, 16'(2 * k), 8'h00, seg_expect(hexb[k][3:0]));
            add_row(2, k_hex, 16'(2 * k + 1), 8'h00, seg_expect(hexb[k][7:4]));
        end
        v = 8'($urandom);
        add_row(2, k_write, 16'h7FF7, v, 8'h00);
        add_row(2, k_led, 16'h0000, 8'h00, v);
        v = 8'($urandom);
        add_row(2, k_sw, 16'h0000, v, 8'h00);
        add_row(2, k_read, 16'h7FF7, 8'h00, v);
        v = 8'($urandom);
        add_row(3, k_uart, 16'h7FF4, v, v);
        add_row(3, k_uart, 16'h7FF4, 8'h01, 8'h01);
        v = 8'($urandom);
        add_row(4, k_uart_bp, 16'h7FF4, v, v);
        add_row(5, k_irqb, 16'h0000, 8'h00, 8'h00);
        add_row(5, k_read, 16'h7FF6, 8'h00, 8'h02);
        add_row(5, k_btn, 16'h0000, 8'h00, 8'h00);
        add_row(5, k_read, 16'h7FF6, 8'h00, 8'h03);
        add_row(5, k_btn, 16'h0000, 8'h01, 8'h00);
        add_row(5, k_write, 16'h7FF6, 8'hFE, 8'h00);
        add_row(5, k_read, 16'h7FF6, 8'h00, 8'h02);
        add_row(5, k_irqb, 16'h0000, 8'h00, 8'h00);
        add_row(5, k_write, 16'h7FF6, 8'h00, 8'h00);
        add_row(5, k_read, 16'h7FF6, 8'h00, 8'h00);
        add_row(5, k_irqb, 16'h0000, 8'h00, 8'h01);
    endtask

    task automatic report_group(input int g);
        $display("test %0d %s: %0d checks, %0d errors", g + 1, grp_name[g],
                 n_checks - grp_checks, n_errors - grp_errors);
        n_tests++;
        grp_checks = n_checks;
        grp_errors = n_errors;
    endtask

    initial begin
        int cur_grp;
        rst         = 1'b1;
        cpu_addr    = 16'h0000;
        cpu_rwb     = 1'b1;
        cpu_data_in = 8'h00;
        button      = 1'b1;
        sw          = 8'h00;
        cur_grp     = 0;
        void'($urandom(32'hc7fadb05));
        build_table();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < op_q.size() && !timed_out; r++) begin
            if (grp_q[r] != cur_grp) begin
                report_group(cur_grp);
                cur_grp = grp_q[r];
            end
            run_row(r);
        end
        report_group(cur_grp);
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: super6502_top.sv
`timescale 1ns/1ps

module super6502_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [bus_map_pkg::addr_w-1:0] cpu_addr,
    input  logic                           cpu_rwb,
    input  logic [bus_map_pkg::data_w-1:0] cpu_data_in,
    input  logic                           button,
    input  logic [7:0]                     sw,
    output logic [bus_map_pkg::data_w-1:0] cpu_data_out,
    output logic                           cpu_irqb,
    output logic [6:0]                     hex0,
    output logic [6:0]                     hex1,
    output logic [6:0]                     hex2,
    output logic [6:0]                     hex3,
    output logic [6:0]                     hex4,
    output logic [6:0]                     hex5,
    output logic [7:0]                     led,
    output logic                           uart_txd
);

    logic       we;
    logic       ram_cs, rom_cs, hex_cs, uart_cs, irq_cs, board_io_cs;
    logic [7:0] ram_rdata, rom_rdata, uart_rdata, irq_rdata, board_io_rdata;
    logic       uart_done;

    assign we = ~cpu_rwb;

    addr_decode addr_decode_i (
        .addr        (cpu_addr),
        .ram_cs      (ram_cs),
        .rom_cs      (rom_cs),
        .hex_cs      (hex_cs),
        .uart_cs     (uart_cs),
        .irq_cs      (irq_cs),
        .board_io_cs (board_io_cs)
    );

    boot_rom boot_rom_i (
        .addr (cpu_addr[bus_map_pkg::rom_addr_w-1:0]),
        .data (rom_rdata)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .cs    (ram_cs),
        .we    (we),
        .addr  (cpu_addr[bus_map_pkg::ram_addr_w-1:0]),
        .wdata (cpu_data_in),
        .rdata (ram_rdata)
    );

    seven_seg seven_seg_i (
        .clk   (clk),
        .rst   (rst),
        .cs    (hex_cs),
        .we    (we),
        .addr  (cpu_addr[bus_map_pkg::hex_addr_w-1:0]),
        .wdata (cpu_data_in),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5)
    );

    board_io board_io_i (
        .clk   (clk),
        .rst   (rst),
        .cs    (board_io_cs),
        .we    (we),
        .wdata (cpu_data_in),
        .sw    (sw),
        .rdata (board_io_rdata),
        .led   (led)
    );

    uart_tx_fsm uart_tx_fsm_i (
        .clk     (clk),
        .rst     (rst),
        .cs      (uart_cs),
        .we      (we),
        .addr    (cpu_addr[bus_map_pkg::uart_addr_w-1:0]),
        .wdata   (cpu_data_in),
        .rdata   (uart_rdata),
        .txd     (uart_txd),
        .tx_done (uart_done)
    );

    irq_ctrl irq_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .cs        (irq_cs),
        .we        (we),
        .wdata     (cpu_data_in),
        .button    (button),
        .uart_done (uart_done),
        .rdata     (irq_rdata),
        .irqb      (cpu_irqb)
    );

    // display is write only, so its page reads as unmapped
    always_comb begin
        if (ram_cs)
            cpu_data_out = ram_rdata;
        else if (rom_cs)
            cpu_data_out = rom_rdata;
        else if (uart_cs)
            cpu_data_out = uart_rdata;
        else if (irq_cs)
            cpu_data_out = irq_rdata;
        else if (board_io_cs)
            cpu_data_out = board_io_rdata;
        else
            cpu_data_out = bus_map_pkg::unmapped_data;
    end

endmodule

// File: irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs,
    input  logic       we,
    input  logic [7:0] wdata,
    input  logic       button,
    input  logic       uart_done,
    output logic [7:0] rdata,
    output logic       irqb
);

    logic [7:0] irq_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_reg <= '0;
        end else if (cs && we) begin
            irq_reg <= irq_reg & wdata;  // clear wins over set
        end else begin
            if (!button) irq_reg[periph_pkg::irq_button_bit] <= 1'b1;
            if (uart_done) irq_reg[periph_pkg::irq_uart_bit] <= 1'b1;
        end
    end

    assign rdata = irq_reg;
    assign irqb  = ~|irq_reg;

endmodule

// File: uart_tx_fsm.sv
`timescale 1ns/1ps

module uart_tx_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs,
    input  logic       we,
    input  logic [0:0] addr,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic       txd,
    output logic       tx_done
);

    logic [1:0]                        state;
    logic [periph_pkg::uart_idx_w-1:0] bit_idx;
    logic [7:0]                        tx_shift;
    logic                              busy;
    logic                              baud_en;
    logic                              bit_tick;
    logic                              start_wr;

    assign busy     = state != periph_pkg::uart_st_idle;
    assign baud_en  = busy;
    assign start_wr = cs && we && (addr == periph_pkg::uart_tx_off) && !busy;  // drop when busy

    baud_timer baud_timer_i (
        .clk  (clk),
        .rst  (rst),
        .en   (baud_en),
        .tick (bit_tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= periph_pkg::uart_st_idle;
            bit_idx <= '0;
        end else begin
            case (state)
                periph_pkg::uart_st_idle: begin
                    if (start_wr) state <= periph_pkg::uart_st_start;
                end
                periph_pkg::uart_st_start: begin
                    if (bit_tick) begin
                        state   <= periph_pkg::uart_st_data;
                        bit_idx <= '0;
                    end
                end
                periph_pkg::uart_st_data: begin
                    if (bit_tick) begin
                        if (bit_idx == periph_pkg::uart_bit_last) begin
                            state <= periph_pkg::uart_st_stop;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) state <= periph_pkg::uart_st_idle;  // end of stop bit
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_wr) begin
            tx_shift <= wdata;
        end else if (state == periph_pkg::uart_st_data && bit_tick) begin
            tx_shift <= {1'b0, tx_shift[7:1]};  // lsb first
        end
    end

    always_comb begin
        case (state)
            periph_pkg::uart_st_start: txd = 1'b0;
            periph_pkg::uart_st_data:  txd = tx_shift[0];
            default:                   txd = 1'b1;  // idle and stop
        endcase
    end

    assign tx_done = (state == periph_pkg::uart_st_stop) && bit_tick;
    assign rdata   = (addr == periph_pkg::uart_stat_off) ? {7'b0, busy} : 8'h00;

endmodule

// File: baud_timer.sv
`timescale 1ns/1ps

module baud_timer (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic tick
);

    logic [periph_pkg::uart_cnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst || !en) begin
            cnt <= '0;  // restart phase on every enable
        end else if (cnt == periph_pkg::uart_cnt_last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // last cycle of each bit period
    assign tick = en && (cnt == periph_pkg::uart_cnt_last);

endmodule

// File: board_io.sv
`timescale 1ns/1ps

module board_io (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs,
    input  logic       we,
    input  logic [7:0] wdata,
    input  logic [7:0] sw,
    output logic [7:0] rdata,
    output logic [7:0] led
);

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= periph_pkg::led_reset;
        end else if (cs && we) begin
            led <= wdata;
        end
    end

    // switches read straight through
    assign rdata = sw;

endmodule

// File: seven_seg.sv
`timescale 1ns/1ps

module seven_seg (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs,
    input  logic       we,
    input  logic [1:0] addr,
    input  logic [7:0] wdata,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5
);

    logic [7:0] disp_byte [periph_pkg::hex_reg_cnt];

    // segment a in bit 0, g in bit 6, active low
    function automatic logic [6:0] seg_decode(input logic [3:0] nib);
        logic [6:0] on;
        case (nib)
            4'h0: on = 7'h3F;
            4'h1: on = 7'h06;
            4'h2: on = 7'h5B;
            4'h3: on = 7'h4F;
            4'h4: on = 7'h66;
            4'h5: on = 7'h6D;
            4'h6: on = 7'h7D;
            4'h7: on = 7'h07;
            4'h8: on = 7'h7F;
            4'h9: on = 7'h6F;
            4'hA: on = 7'h77;
            4'hB: on = 7'h7C;
            4'hC: on = 7'h39;
            4'hD: on = 7'h5E;
            4'hE: on = 7'h79;
            default: on = 7'h71;
        endcase
        return ~on;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < periph_pkg::hex_reg_cnt; i++) begin
                disp_byte[i] <= periph_pkg::hex_reset;
            end
        end else if (cs && we && addr < periph_pkg::hex_reg_cnt) begin
            disp_byte[addr] <= wdata;  // offset 3 has no register
        end
    end

    assign hex0 = seg_decode(disp_byte[0][3:0]);
    assign hex1 = seg_decode(disp_byte[0][7:4]);
    assign hex2 = seg_decode(disp_byte[1][3:0]);
    assign hex3 = seg_decode(disp_byte[1][7:4]);
    assign hex4 = seg_decode(disp_byte[2][3:0]);
    assign hex5 = seg_decode(disp_byte[2][7:4]);

endmodule

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                               clk,
    input  logic                               cs,
    input  logic                               we,
    input  logic [bus_map_pkg::ram_addr_w-1:0] addr,
    input  logic [bus_map_pkg::data_w-1:0]     wdata,
    output logic [bus_map_pkg::data_w-1:0]     rdata
);

    logic [bus_map_pkg::data_w-1:0] mem [2**bus_map_pkg::ram_addr_w];

    always_ff @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];  // async read, same cycle as address

endmodule

// File: boot_rom.sv
`timescale 1ns/1ps

module boot_rom (
    input  logic [bus_map_pkg::rom_addr_w-1:0] addr,
    output logic [bus_map_pkg::data_w-1:0]     data
);

    always_comb begin
        case (addr)
            6'h00: data = 8'hA2;    // ldx #$ff
            6'h01: data = 8'hFF;
            6'h02: data = 8'h9A;    // txs
            6'h03: data = 8'h58;    // cli
            6'h04: data = 8'hA9;    // lda #'H'
            6'h05: data = 8'h48;
            6'h06: data = 8'h8D;    // sta uart tx
            6'h07: data = 8'hF4;
            6'h08: data = 8'h7F;
            6'h09: data = 8'hAD;    // lda uart status
            6'h0A: data = 8'hF5;
            6'h0B: data = 8'h7F;
            6'h0C: data = 8'hD0;    // bne, wait for idle
            6'h0D: data = 8'hFB;
            6'h0E: data = 8'hAD;    // lda switches
            6'h0F: data = 8'hF7;
            6'h10: data = 8'h7F;
            6'h11: data = 8'h8D;    // sta leds
            6'h12: data = 8'hF7;
            6'h13: data = 8'h7F;
            6'h14: data = 8'h8D;    // sta hex byte 0
            6'h15: data = 8'hF0;
            6'h16: data = 8'h7F;
            6'h17: data = 8'h4C;    // jmp $800e
            6'h18: data = 8'h0E;
            6'h19: data = 8'h80;
            6'h30: data = 8'h48;    // irq handler: pha
            6'h31: data = 8'hA9;    // lda #0
            6'h32: data = 8'h00;
            6'h33: data = 8'h8D;    // sta irq latch, clears all
            6'h34: data = 8'hF6;
            6'h35: data = 8'h7F;
            6'h36: data = 8'h68;    // pla
            6'h37: data = 8'h40;    // rti
            6'h3A: data = 8'h30;    // nmi vector
            6'h3B: data = 8'h80;
            6'h3C: data = 8'h00;    // reset vector $8000
            6'h3D: data = 8'h80;
            6'h3E: data = 8'h30;    // irq vector $8030
            6'h3F: data = 8'h80;
            default: data = 8'hEA;  // nop fill
        endcase
    end

endmodule

// File: addr_decode.sv
`timescale 1ns/1ps

module addr_decode (
    input  logic [bus_map_pkg::addr_w-1:0] addr,
    output logic                           ram_cs,
    output logic                           rom_cs,
    output logic                           hex_cs,
    output logic                           uart_cs,
    output logic                           irq_cs,
    output logic                           board_io_cs
);

    logic io_page;

    // upper 12 bits select the i/o page
    assign io_page = addr[bus_map_pkg::addr_w-1:bus_map_pkg::io_page_w] ==
                     bus_map_pkg::io_base[bus_map_pkg::addr_w-1:bus_map_pkg::io_page_w];

    assign ram_cs = (addr >= bus_map_pkg::ram_base) && (addr <= bus_map_pkg::ram_last);
    assign rom_cs = addr >= bus_map_pkg::rom_base;  // any address with bit 15 set

    assign hex_cs = io_page &&
        addr[bus_map_pkg::io_page_w-1:bus_map_pkg::hex_addr_w] ==
        bus_map_pkg::hex_base[bus_map_pkg::io_page_w-1:bus_map_pkg::hex_addr_w];

    assign uart_cs = io_page &&
        addr[bus_map_pkg::io_page_w-1:bus_map_pkg::uart_addr_w] ==
        bus_map_pkg::uart_base[bus_map_pkg::io_page_w-1:bus_map_pkg::uart_addr_w];

    assign irq_cs      = addr == bus_map_pkg::irq_addr;
    assign board_io_cs = addr == bus_map_pkg::board_io_addr;

endmodule

// File: periph_pkg.sv
package periph_pkg;

    // uart register offsets
    localparam logic [0:0] uart_tx_off   = 1'b0;  // write starts a frame
    localparam logic [0:0] uart_stat_off = 1'b1;  // bit 0 busy

    // uart timing
    localparam int uart_clks_per_bit = 16;
    localparam int uart_cnt_w        = 4;
    localparam logic [uart_cnt_w-1:0] uart_cnt_last =
        uart_cnt_w'(uart_clks_per_bit - 1);

    localparam int uart_data_bits = 8;
    localparam int uart_idx_w     = 3;
    localparam logic [uart_idx_w-1:0] uart_bit_last =
        uart_idx_w'(uart_data_bits - 1);

    // uart tx fsm encoding
    localparam logic [1:0] uart_st_idle  = 2'd0;
    localparam logic [1:0] uart_st_start = 2'd1;
    localparam logic [1:0] uart_st_data  = 2'd2;
    localparam logic [1:0] uart_st_stop  = 2'd3;

    // irq latch bits
    localparam int irq_button_bit = 0;
    localparam int irq_uart_bit   = 1;

    // display
    localparam int hex_reg_cnt = 3;

    // reset values
    localparam logic [7:0] led_reset = 8'h00;
    localparam logic [7:0] hex_reset = 8'h00;

endpackage

// File: bus_map_pkg.sv
package bus_map_pkg;

    // cpu bus
    localparam int addr_w = 16;
    localparam int data_w = 8;

    // region widths in address bits
    localparam int rom_depth   = 64;
    localparam int rom_addr_w  = $clog2(rom_depth);
    localparam int ram_addr_w  = 8;
    localparam int io_page_w   = 4;    // 16 byte i/o page
    localparam int hex_addr_w  = 2;
    localparam int uart_addr_w = 1;

    // ram window
    localparam logic [addr_w-1:0] ram_base = 16'h0000;
    localparam logic [addr_w-1:0] ram_last = 16'h00FF;

    // i/o page layout
    localparam logic [addr_w-1:0] io_base       = 16'h7FF0;
    localparam logic [addr_w-1:0] hex_base      = 16'h7FF0;  // bytes 0..2 used
    localparam logic [addr_w-1:0] uart_base     = 16'h7FF4;
    localparam logic [addr_w-1:0] irq_addr      = 16'h7FF6;
    localparam logic [addr_w-1:0] board_io_addr = 16'h7FF7;

    // rom aliased over the whole upper half
    localparam logic [addr_w-1:0] rom_base = 16'h8000;

    localparam logic [data_w-1:0] unmapped_data = 8'hFF;

endpackage
